/* Bender.yml */
package:
  name: bpu

sources:
  - files:
      - design/bpu_pkg.sv
      - design/pred_table.sv
      - design/inst_predecode.sv
      - design/direction_predictor.sv
      - design/return_stack.sv
      - design/target_select.sv
      - design/bpu_top.sv

  - target: test
    files:
      - testbench/bpu_properties.sv
      - testbench/bpu_tb.sv

/* design/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    // datapath and table sizes
    localparam int XLEN        = 32;
    localparam int HIST_W      = 16;
    localparam int BIM_ENTRIES = 512;
    localparam int TAG_ENTRIES = 256;
    localparam int TAG_W       = 10;
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_TAG_W   = 22;
    localparam int RAS_DEPTH   = 64;

    // derived index widths
    localparam int BIM_IDX_W = $clog2(BIM_ENTRIES); // pc[9:1]
    localparam int TAG_IDX_W = $clog2(TAG_ENTRIES); // pc[7:0] ^ hist[7:0]
    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES); // pc[9:2]
    localparam int RAS_IDX_W = $clog2(RAS_DEPTH);
    localparam int RAS_PTR_W = RAS_IDX_W + 1;       // one extra bit to tell full from empty

    // rv32 control transfer opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // 2-bit saturating counter points
    localparam logic [1:0] CNT_WEAK_NT = 2'b01; // reset value
    localparam logic [1:0] CNT_WEAK_T  = 2'b10;

    typedef enum logic {
        PROV_BIMODAL = 1'b0,
        PROV_TAGGED  = 1'b1
    } provider_e;

    typedef struct packed {
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            is_ret;
        logic [XLEN-1:0] branch_off;
        logic [XLEN-1:0] jal_off;
    } pdec_t;

    typedef struct packed {
        logic              is_ctrl;
        logic              taken;
        logic [XLEN-1:0]   target;
        provider_e         provider;
        logic [HIST_W-1:0] history; // history seen at prediction time
    } pred_t;

    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic              is_ret;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   target;
        logic [HIST_W-1:0] history;
        provider_e         provider;
    } resolve_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [1:0]       cnt;
    } tag_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

endpackage

`default_nettype wire

/* design/bpu_top.sv */
`default_nettype none

module bpu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]   if_inst_i,
    input  logic                       ras_push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]   ras_push_addr_i,
    input  logic                       stall_i,
    input  bpu_pkg::resolve_t          resolve_i,
    output bpu_pkg::pred_t             pred_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);

    import bpu_pkg::*;

    pdec_t           pdec;
    logic            dir_taken;
    provider_e       provider;
    logic [XLEN-1:0] ras_top;
    logic            ras_nonempty;

    inst_predecode u_predecode (
        .if_inst_i (if_inst_i),
        .pdec_o    (pdec)
    );

    direction_predictor u_dir (
        .clk         (clk),
        .rst         (rst),
        .if_pc_i     (if_pc_i),
        .pdec_i      (pdec),
        .resolve_i   (resolve_i),
        .dir_taken_o (dir_taken),
        .provider_o  (provider),
        .history_o   (history_o)
    );

    return_stack u_ras (
        .clk          (clk),
        .rst          (rst),
        .resolve_i    (resolve_i),
        .stall_i      (stall_i),
        .push_valid_i (ras_push_valid_i),
        .push_addr_i  (ras_push_addr_i),
        .top_o        (ras_top),
        .nonempty_o   (ras_nonempty)
    );

    target_select u_tgt (
        .clk            (clk),
        .rst            (rst),
        .if_pc_i        (if_pc_i),
        .pdec_i         (pdec),
        .dir_taken_i    (dir_taken),
        .provider_i     (provider),
        .history_i      (history_o),
        .ras_top_i      (ras_top),
        .ras_nonempty_i (ras_nonempty),
        .resolve_i      (resolve_i),
        .pred_o         (pred_o)
    );

endmodule

`default_nettype wire

/* design/direction_predictor.sv */
`default_nettype none

module direction_predictor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  bpu_pkg::pdec_t             pdec_i,
    input  bpu_pkg::resolve_t          resolve_i,
    output logic                       dir_taken_o,
    output bpu_pkg::provider_e         provider_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);

    import bpu_pkg::*;

    function automatic logic [TAG_IDX_W-1:0] tag_idx(
        input logic [XLEN-1:0]   pc,
        input logic [HIST_W-1:0] hist
    );
        return pc[TAG_IDX_W-1:0] ^ hist[TAG_IDX_W-1:0];
    endfunction

    // pc[17:8] folded with the oldest history bits
    function automatic logic [TAG_W-1:0] tag_of(
        input logic [XLEN-1:0]   pc,
        input logic [HIST_W-1:0] hist
    );
        return pc[TAG_IDX_W +: TAG_W] ^ hist[HIST_W-1 -: TAG_W];
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'b11) ? cnt : cnt + 2'b01;
        end
        return (cnt == 2'b00) ? cnt : cnt - 2'b01;
    endfunction

    logic [HIST_W-1:0] hist_q;

    logic [1:0]       bim_cnt;
    logic [1:0]       bim_old;
    logic [1:0]       bim_new;
    tag_entry_t       tag_rd;
    tag_entry_t       tag_old;
    tag_entry_t       tag_new;
    logic             tag_hit;
    logic             tag_wr_en;
    logic [TAG_W-1:0] upd_tag;

    // lookup side
    assign tag_hit     = tag_rd.valid && (tag_rd.tag == tag_of(if_pc_i, hist_q));
    assign dir_taken_o = pdec_i.is_branch && (tag_hit ? tag_rd.cnt[1] : bim_cnt[1]);
    assign provider_o  = (pdec_i.is_branch && tag_hit) ? PROV_TAGGED : PROV_BIMODAL;
    assign history_o   = hist_q;

    // update side, hashed with the history the branch was predicted with
    assign upd_tag = tag_of(resolve_i.pc, resolve_i.history);
    assign bim_new = sat_step(bim_old, resolve_i.taken);

    always_comb begin
        tag_new   = tag_old;
        tag_wr_en = 1'b0;
        if (resolve_i.provider == PROV_TAGGED) begin
            tag_wr_en = resolve_i.valid;
            if (resolve_i.correct) begin
                tag_new.cnt = sat_step(tag_old.cnt, resolve_i.taken);
            end else begin
                tag_new.cnt = resolve_i.taken ? 2'b11 : 2'b00; // jump to strong
            end
        end else if (!resolve_i.correct && !(tag_old.valid && tag_old.tag == upd_tag)) begin
            // bimodal missed, claim the slot for this context
            tag_wr_en     = resolve_i.valid;
            tag_new.valid = 1'b1;
            tag_new.tag   = upd_tag;
            tag_new.cnt   = resolve_i.taken ? CNT_WEAK_T : CNT_WEAK_NT;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (resolve_i.valid) begin
            hist_q <= {hist_q[HIST_W-2:0], resolve_i.taken};
        end
    end

    pred_table #(
        .entry_t   (logic [1:0]),
        .ENTRIES   (BIM_ENTRIES),
        .RESET_VAL (CNT_WEAK_NT)
    ) u_bimodal (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (if_pc_i[BIM_IDX_W:1]),
        .rd_entry_o (bim_cnt),
        .wr_en_i    (resolve_i.valid),
        .wr_idx_i   (resolve_i.pc[BIM_IDX_W:1]),
        .wr_entry_i (bim_new),
        .wr_old_o   (bim_old)
    );

    pred_table #(
        .entry_t   (tag_entry_t),
        .ENTRIES   (TAG_ENTRIES),
        .RESET_VAL ('0)
    ) u_tagged (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (tag_idx(if_pc_i, hist_q)),
        .rd_entry_o (tag_rd),
        .wr_en_i    (tag_wr_en),
        .wr_idx_i   (tag_idx(resolve_i.pc, resolve_i.history)),
        .wr_entry_i (tag_new),
        .wr_old_o   (tag_old)
    );

endmodule

`default_nettype wire

/* design/inst_predecode.sv */
`default_nettype none

module inst_predecode (
    input  logic [bpu_pkg::XLEN-1:0] if_inst_i,
    output bpu_pkg::pdec_t           pdec_o
);

    import bpu_pkg::*;

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm_i;
    logic        link_src; // rs1 is ra or t0

    assign opcode   = if_inst_i[6:0];
    assign rd       = if_inst_i[11:7];
    assign rs1      = if_inst_i[19:15];
    assign imm_i    = if_inst_i[31:20];
    assign link_src = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign pdec_o.is_branch = (opcode == OP_BRANCH);
    assign pdec_o.is_jal    = (opcode == OP_JAL);
    assign pdec_o.is_jalr   = (opcode == OP_JALR);

    // jalr x0, 0(ra|t0)
    assign pdec_o.is_ret = (opcode == OP_JALR) && (rd == 5'd0) && link_src && (imm_i == 12'd0);

    // b-type immediate
    assign pdec_o.branch_off = {
        {(XLEN-12){if_inst_i[31]}},
        if_inst_i[7],
        if_inst_i[30:25],
        if_inst_i[11:8],
        1'b0
    };

    // j-type immediate
    assign pdec_o.jal_off = {
        {(XLEN-20){if_inst_i[31]}},
        if_inst_i[19:12],
        if_inst_i[20],
        if_inst_i[30:21],
        1'b0
    };

endmodule

`default_nettype wire

/* design/pred_table.sv */
`default_nettype none

module pred_table #(
    parameter type    entry_t   = logic [1:0],
    parameter int     ENTRIES   = 256,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(ENTRIES)-1:0]  rd_idx_i,
    output entry_t                      rd_entry_o,
    input  logic                        wr_en_i,
    input  logic [$clog2(ENTRIES)-1:0]  wr_idx_i,
    input  entry_t                      wr_entry_i,
    output entry_t                      wr_old_o
);

    entry_t mem_q [ENTRIES];

    assign rd_entry_o = mem_q[rd_idx_i]; // lookup, same cycle
    assign wr_old_o   = mem_q[wr_idx_i]; // old value for read-modify-write updates

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mem_q[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_entry_i;
        end
    end

endmodule

`default_nettype wire

/* design/return_stack.sv */
`default_nettype none

module return_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  bpu_pkg::resolve_t        resolve_i,
    input  logic                     stall_i,
    input  logic                     push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] push_addr_i,
    output logic [bpu_pkg::XLEN-1:0] top_o,
    output logic                     nonempty_o
);

    import bpu_pkg::*;

    logic [XLEN-1:0] stack_q [RAS_DEPTH];

    logic [RAS_PTR_W-1:0] sp_q;   // next free slot
    logic [RAS_PTR_W-1:0] sp_top; // slot of the current top
    logic [RAS_PTR_W-1:0] sp_pop; // pointer once the pop is applied
    logic [RAS_PTR_W-1:0] sp_d;
    logic                 pop;
    logic                 push;

    assign nonempty_o = (sp_q != '0);
    assign sp_top     = sp_q - 1'b1;
    assign top_o      = stack_q[sp_top[RAS_IDX_W-1:0]];

    // returns pop at execute, calls push at decode
    assign pop = resolve_i.valid && resolve_i.taken && resolve_i.is_ret
                 && !stall_i && nonempty_o;
    assign sp_pop = pop ? sp_top : sp_q;

    // pop goes first, so a push in the same cycle lands where the pop left
    assign push = push_valid_i && !stall_i && (sp_pop != RAS_PTR_W'(RAS_DEPTH));
    assign sp_d = push ? sp_pop + 1'b1 : sp_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_d;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[sp_pop[RAS_IDX_W-1:0]] <= push_addr_i;
        end
    end

endmodule

`default_nettype wire

/* design/target_select.sv */
`default_nettype none

module target_select (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input  bpu_pkg::pdec_t             pdec_i,
    input  logic                       dir_taken_i,
    input  bpu_pkg::provider_e         provider_i,
    input  logic [bpu_pkg::HIST_W-1:0] history_i,
    input  logic [bpu_pkg::XLEN-1:0]   ras_top_i,
    input  logic                       ras_nonempty_i,
    input  bpu_pkg::resolve_t          resolve_i,
    output bpu_pkg::pred_t             pred_o
);

    import bpu_pkg::*;

    btb_entry_t      btb_rd;
    btb_entry_t      btb_wr;
    logic            btb_hit;
    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = if_pc_i + XLEN'(4);
    assign btb_hit  = btb_rd.valid && (btb_rd.tag == if_pc_i[XLEN-1 -: BTB_TAG_W]);

    // taken resolves fill the btb
    assign btb_wr.valid  = 1'b1;
    assign btb_wr.tag    = resolve_i.pc[XLEN-1 -: BTB_TAG_W];
    assign btb_wr.target = resolve_i.target;

    always_comb begin
        pred_o.is_ctrl  = pdec_i.is_branch || pdec_i.is_jal || pdec_i.is_jalr;
        pred_o.taken    = 1'b0;
        pred_o.target   = pc_plus4; // fall through
        pred_o.provider = provider_i;
        pred_o.history  = history_i;
        if (pdec_i.is_ret) begin
            if (ras_nonempty_i) begin
                pred_o.taken  = 1'b1;
                pred_o.target = ras_top_i;
            end
        end else if (pdec_i.is_jal) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit ? btb_rd.target : if_pc_i + pdec_i.jal_off;
        end else if (pdec_i.is_branch && dir_taken_i) begin
            pred_o.taken  = 1'b1;
            pred_o.target = btb_hit ? btb_rd.target : if_pc_i + pdec_i.branch_off;
        end
        // other jalr stays not taken
    end

    pred_table #(
        .entry_t   (btb_entry_t),
        .ENTRIES   (BTB_ENTRIES),
        .RESET_VAL ('0)
    ) u_btb (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (if_pc_i[BTB_IDX_W+1:2]),
        .rd_entry_o (btb_rd),
        .wr_en_i    (resolve_i.valid && resolve_i.taken),
        .wr_idx_i   (resolve_i.pc[BTB_IDX_W+1:2]),
        .wr_entry_i (btb_wr),
        .wr_old_o   ()
    );

endmodule

`default_nettype wire

/* testbench/bpu_properties.sv */
`default_nettype none

module bpu_properties (
    input logic                       clk,
    input logic                       rst,
    input logic [bpu_pkg::XLEN-1:0]   if_pc_i,
    input bpu_pkg::pred_t             pred_o,
    input logic [bpu_pkg::HIST_W-1:0] history_o
);

    import bpu_pkg::*;

    int unsigned fail_cnt = 0; // polled by the testbench

    // only a control transfer may be predicted taken
    taken_is_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_o.taken |-> pred_o.is_ctrl)
    else begin
        fail_cnt++;
        $error("taken prediction on an instruction that is not a control transfer");
    end

    // everything else falls through
    plain_falls_through: assert property (@(posedge clk) disable iff (rst)
        !pred_o.is_ctrl |-> (pred_o.target == if_pc_i + XLEN'(4)))
    else begin
        fail_cnt++;
        $error("non-control instruction did not predict pc+4");
    end

    history_clear_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (history_o == '0))
    else begin
        fail_cnt++;
        $error("global history not zero in the cycle after reset");
    end

endmodule

`default_nettype wire

/* testbench/bpu_tb.sv */
`default_nettype none

module bpu_tb;

    import bpu_pkg::*;

    localparam int              CLK_PERIOD     = 20;
    localparam int              TIMEOUT_CYCLES = 400; // stimulus needs about 70 cycles
    localparam int unsigned     SEED           = 32'h60385e45;
    localparam logic [XLEN-1:0] NOP            = 32'h0000_0013;
    localparam logic [XLEN-1:0] FILL_PC        = 32'h0000_13f0; // only used to steer history

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   if_pc_i;
    logic [XLEN-1:0]   if_inst_i;
    logic              ras_push_valid_i;
    logic [XLEN-1:0]   ras_push_addr_i;
    logic              stall_i;
    resolve_t          resolve_i;
    pred_t             pred_o;
    logic [HIST_W-1:0] history_o;

    logic [HIST_W-1:0] hist_model;    // expected global history
    int unsigned       cycle_cnt = 0;

    bpu_top dut (
        .clk              (clk),
        .rst              (rst),
        .if_pc_i          (if_pc_i),
        .if_inst_i        (if_inst_i),
        .ras_push_valid_i (ras_push_valid_i),
        .ras_push_addr_i  (ras_push_addr_i),
        .stall_i          (stall_i),
        .resolve_i        (resolve_i),
        .pred_o           (pred_o),
        .history_o        (history_o)
    );

    bind bpu_top bpu_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .if_pc_i   (if_pc_i),
        .pred_o    (pred_o),
        .history_o (history_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the test sequence did not finish in time");
        end
    end

    always @(negedge clk) begin
        if (dut.u_props.fail_cnt != 0) begin
            abort_run("a bound property on the DUT ports failed");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [XLEN-1:0] exp_val,
                             input logic [XLEN-1:0] act_val);
        assert (act_val === exp_val)
        else abort_run($sformatf("Error: %s expected 0x%08h actual 0x%08h",
                                 name, exp_val, act_val));
    endtask

    // beq x1, x2, off
    function automatic logic [XLEN-1:0] enc_branch(input logic [XLEN-1:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [XLEN-1:0] enc_jal(input logic [4:0] rd,
                                                input logic [XLEN-1:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [XLEN-1:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [XLEN-1:0] rand_pc(input logic [9:0] low);
        logic [XLEN-1:0] r;
        r = $urandom;
        return {r[XLEN-1:10], low}; // low bits keep table slots apart
    endfunction

    function automatic logic [XLEN-1:0] rand_boff();
        logic [XLEN-1:0] r;
        r = $urandom;
        return {{19{r[12]}}, r[12:1], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] rand_joff();
        logic [XLEN-1:0] r;
        r = $urandom;
        return {{11{r[20]}}, r[20:1], 1'b0};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
        resolve_i        = '0;
        ras_push_valid_i = 1'b0;
        stall_i          = 1'b0;
        check_val("history", XLEN'(hist_model), XLEN'(history_o));
    endtask

    task automatic send_resolve(input logic [XLEN-1:0] pc, input logic taken,
                                input logic correct, input logic is_ret,
                                input logic [XLEN-1:0] target,
                                input logic [HIST_W-1:0] hist, input provider_e prov);
        next_cycle();
        resolve_i.valid    = 1'b1;
        resolve_i.taken    = taken;
        resolve_i.correct  = correct;
        resolve_i.is_ret   = is_ret;
        resolve_i.pc       = pc;
        resolve_i.target   = target;
        resolve_i.history  = hist;
        resolve_i.provider = prov;
        hist_model = {hist_model[HIST_W-2:0], taken}; // seen after the edge
    endtask

    // shift in all bits of h, oldest first
    task automatic load_history(input logic [HIST_W-1:0] h);
        for (int i = HIST_W - 1; i >= 0; i--) begin
            send_resolve(FILL_PC, h[i], 1'b1, 1'b0, FILL_PC + 32'd8, hist_model, PROV_BIMODAL);
        end
    endtask

    task automatic push_ras(input logic [XLEN-1:0] addr, input logic stalled);
        next_cycle();
        ras_push_valid_i = 1'b1;
        ras_push_addr_i  = addr;
        stall_i          = stalled;
    endtask

    task automatic fetch_check(input string name, input logic [XLEN-1:0] pc,
                               input logic [XLEN-1:0] inst, input logic exp_taken,
                               input logic [XLEN-1:0] exp_target, input provider_e exp_prov);
        logic exp_ctrl;
        next_cycle();
        if_pc_i   = pc;
        if_inst_i = inst;
        exp_ctrl  = (inst[6:0] == 7'b1100011) || (inst[6:0] == 7'b1101111)
                    || (inst[6:0] == 7'b1100111);
        #5; // combinational path settles
        check_val({name, " is_ctrl"}, XLEN'(exp_ctrl), XLEN'(pred_o.is_ctrl));
        check_val({name, " taken"}, XLEN'(exp_taken), XLEN'(pred_o.taken));
        check_val({name, " target"}, exp_target, pred_o.target);
        check_val({name, " provider"}, XLEN'(exp_prov), XLEN'(pred_o.provider));
        check_val({name, " history"}, XLEN'(hist_model), XLEN'(pred_o.history));
    endtask

    initial begin
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   off;
        logic [XLEN-1:0]   tgt;
        logic [XLEN-1:0]   addr_a;
        logic [XLEN-1:0]   addr_b;
        logic [HIST_W-1:0] hist;
        void'($urandom(SEED));
        rst              = 1'b1;
        if_pc_i          = '0;
        if_inst_i        = NOP;
        ras_push_valid_i = 1'b0;
        ras_push_addr_i  = '0;
        stall_i          = 1'b0;
        resolve_i        = '0;
        hist_model       = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // cold tables
        pc  = rand_pc(10'h040);
        off = rand_boff();
        fetch_check("cold branch", pc, enc_branch(off), 1'b0, pc + 32'd4, PROV_BIMODAL);
        off = rand_joff();
        fetch_check("cold jal", pc, enc_jal(5'd1, off), 1'b1, pc + off, PROV_BIMODAL);
        fetch_check("plain jalr", pc, enc_jalr(5'd1, 5'd6, 12'd0), 1'b0, pc + 32'd4,
                    PROV_BIMODAL);
        fetch_check("non-control", pc, NOP, 1'b0, pc + 32'd4, PROV_BIMODAL);

        // bimodal training and btb fill
        pc   = rand_pc(10'h100);
        off  = rand_boff();
        tgt  = pc + off + 32'h0000_1000; // differs from the decoded target
        hist = hist_model;
        send_resolve(pc, 1'b1, 1'b1, 1'b0, tgt, hist, PROV_BIMODAL);
        send_resolve(pc, 1'b1, 1'b1, 1'b0, tgt, hist, PROV_BIMODAL);
        fetch_check("trained branch", pc, enc_branch(off), 1'b1, tgt, PROV_BIMODAL);

        // tagged allocation, then a tagged mispredict flips it
        pc   = rand_pc(10'h200);
        off  = rand_boff();
        tgt  = pc + off + 32'h0000_2000;
        hist = HIST_W'($urandom);
        send_resolve(pc, 1'b0, 1'b0, 1'b0, tgt, hist, PROV_BIMODAL);
        load_history(hist);
        fetch_check("tagged alloc", pc, enc_branch(off), 1'b0, pc + 32'd4, PROV_TAGGED);
        send_resolve(pc, 1'b1, 1'b0, 1'b0, tgt, hist, PROV_TAGGED);
        load_history(hist);
        fetch_check("tagged flip", pc, enc_branch(off), 1'b1, tgt, PROV_TAGGED);

        // return stack
        pc     = rand_pc(10'h080);
        addr_a = {rand_pc(10'h000)} & ~32'd3;
        addr_b = addr_a + 32'h0000_0400;
        fetch_check("empty return", pc, enc_jalr(5'd0, 5'd1, 12'd0), 1'b0, pc + 32'd4,
                    PROV_BIMODAL);
        push_ras(addr_a, 1'b0);
        push_ras(addr_b, 1'b0);
        push_ras(addr_b + 32'h10, 1'b1); // stalled, must be dropped
        fetch_check("return top", pc, enc_jalr(5'd0, 5'd1, 12'd0), 1'b1, addr_b,
                    PROV_BIMODAL);
        send_resolve(pc, 1'b1, 1'b1, 1'b1, addr_b, hist_model, PROV_BIMODAL);
        fetch_check("return after pop", pc, enc_jalr(5'd0, 5'd5, 12'd0), 1'b1, addr_a,
                    PROV_BIMODAL);
        send_resolve(pc, 1'b1, 1'b1, 1'b1, addr_a, hist_model, PROV_BIMODAL);
        fetch_check("return drained", pc, enc_jalr(5'd0, 5'd1, 12'd0), 1'b0, pc + 32'd4,
                    PROV_BIMODAL);

        next_cycle();
        if (dut.u_props.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("a bound property on the DUT ports failed");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
design/bpu_pkg.sv
design/pred_table.sv
design/inst_predecode.sv
design/direction_predictor.sv
design/return_stack.sv
design/target_select.sv
design/bpu_top.sv
testbench/bpu_properties.sv
testbench/bpu_tb.sv
